/* hdl/cam_diag_pkg.sv */
// clks_per_half and sample_interval are sized for simulation; raise them for a real SCL rate
package cam_diag_pkg;

    // widths
    localparam int diag_w     = 16;
    localparam int line_cnt_w = 10;
    localparam int page_w     = 8;
    localparam int rst_cnt_w  = 4;

    // diagnostic pages, cycled in this order
    localparam int page_count = 5;
    localparam logic [page_w-1:0] page_lines  = 8'd0;
    localparam logic [page_w-1:0] page_sof    = 8'd1;
    localparam logic [page_w-1:0] page_vsync  = 8'd2;
    localparam logic [page_w-1:0] page_delta  = 8'd3;
    localparam logic [page_w-1:0] page_status = 8'd4;

    localparam int sample_interval = 2048;

    // i2c logger
    localparam logic [6:0] i2c_addr = 7'h5d;
    localparam int clks_per_half    = 8;
    // four bytes, each followed by its ack slot
    localparam int i2c_frame_bits   = 36;
    // start, two halves per bit, stop low/high, bus free
    localparam int i2c_last_step    = 2 * i2c_frame_bits + 3;

    // one status word, read raw or as flags
    typedef union packed {
        logic [diag_w-1:0] raw;
        struct packed {
            logic [10:0] reserved;
            logic        lock_lost;
            logic        frame_miss;
            logic        resync_seen;
            logic        lock_latched;
            logic        marker_found;
        } flags;
    } diag_word_t;

endpackage

/* hdl/cam_reset_sync.sv */
// assert is immediate on cam_resetn low; release follows 15 cam1_pclk edges, needs a running clock
`timescale 1ns/1ps

module cam_reset_sync (
    input  logic cam1_pclk,
    input  logic cam_resetn,
    output logic diag_resetn
);
    import cam_diag_pkg::*;

    logic [rst_cnt_w-1:0] rst_cnt;

    // counts up once and parks at all ones
    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            rst_cnt <= '0;
        end else if (!diag_resetn) begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    assign diag_resetn = &rst_cnt;

endmodule

/* hdl/field_line_counter.sv */
// line and field inputs must already be synchronous to cam1_pclk; count wraps past 1023 lines
`timescale 1ns/1ps

module field_line_counter (
    input  logic                              cam1_pclk,
    input  logic                              diag_resetn,
    input  logic                              cam_line_valid,
    input  logic                              cam_field_toggle,
    output logic [cam_diag_pkg::line_cnt_w-1:0] lines_per_field_last
);
    import cam_diag_pkg::*;

    logic                  line_valid_d;
    logic                  field_toggle_d;
    logic [line_cnt_w-1:0] line_cnt;
    logic                  line_start;
    logic                  field_start;

    assign line_start  = cam_line_valid & ~line_valid_d;
    assign field_start = cam_field_toggle ^ field_toggle_d;

    always_ff @(posedge cam1_pclk or negedge diag_resetn) begin
        if (!diag_resetn) begin
            line_valid_d         <= 1'b0;
            field_toggle_d       <= 1'b0;
            line_cnt             <= '0;
            lines_per_field_last <= '0;
        end else begin
            line_valid_d   <= cam_line_valid;
            field_toggle_d <= cam_field_toggle;

            if (field_start) begin
                lines_per_field_last <= line_cnt;
                // a line starting on the boundary belongs to the new field
                line_cnt <= line_start ? line_cnt_w'(1) : '0;
            end else if (line_start) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/frame_sync_monitor.sv */
// hdmi_vsync_toggle may be asynchronous; all other inputs must be synchronous to cam1_pclk
`timescale 1ns/1ps

module frame_sync_monitor (
    input  logic                             cam1_pclk,
    input  logic                             diag_resetn,
    input  logic                             cam_field_toggle,
    input  logic                             hdmi_vsync_toggle,
    input  logic                             marker_found,
    input  logic                             resync_used,
    input  logic                             lock_latched,
    output logic [cam_diag_pkg::diag_w-1:0] in_sof_cnt,
    output logic [cam_diag_pkg::diag_w-1:0] out_vsync_cnt,
    output logic [cam_diag_pkg::diag_w-1:0] sof_delta,
    output cam_diag_pkg::diag_word_t        lock_status
);
    import cam_diag_pkg::*;

    logic [2:0] vsync_sync;
    logic       field_toggle_d;
    logic       lock_latched_d;
    logic       lock_lost;
    logic       frame_miss;
    logic       resync_seen;
    logic       vsync_edge;
    logic       field_start;
    logic       lock_rise;

    // two sync stages, third stage only for the edge
    assign vsync_edge  = vsync_sync[2] ^ vsync_sync[1];
    assign field_start = cam_field_toggle ^ field_toggle_d;
    assign lock_rise   = lock_latched & ~lock_latched_d;

    always_ff @(posedge cam1_pclk or negedge diag_resetn) begin
        if (!diag_resetn) begin
            vsync_sync     <= 3'b000;
            field_toggle_d <= 1'b0;
            lock_latched_d <= 1'b0;
            in_sof_cnt     <= '0;
            out_vsync_cnt  <= '0;
        end else begin
            vsync_sync     <= {vsync_sync[1:0], hdmi_vsync_toggle};
            field_toggle_d <= cam_field_toggle;
            lock_latched_d <= lock_latched;
            if (field_start) begin
                in_sof_cnt <= in_sof_cnt + 1'b1;
            end
            if (vsync_edge) begin
                out_vsync_cnt <= out_vsync_cnt + 1'b1;
            end
        end
    end

    // lock rise clears everything; otherwise a set beats the vsync clear
    always_ff @(posedge cam1_pclk or negedge diag_resetn) begin
        if (!diag_resetn) begin
            lock_lost   <= 1'b0;
            frame_miss  <= 1'b0;
            resync_seen <= 1'b0;
        end else if (lock_rise) begin
            lock_lost   <= 1'b0;
            frame_miss  <= 1'b0;
            resync_seen <= 1'b0;
        end else begin
            lock_lost   <= !marker_found | (lock_lost & ~vsync_edge);
            resync_seen <= resync_used | (resync_seen & ~vsync_edge);
            frame_miss  <= (in_sof_cnt != out_vsync_cnt) | (frame_miss & ~vsync_edge);
        end
    end

    assign sof_delta = in_sof_cnt - out_vsync_cnt;

    always_comb begin
        lock_status.flags.reserved     = '0;
        lock_status.flags.lock_lost    = lock_lost;
        lock_status.flags.frame_miss   = frame_miss;
        lock_status.flags.resync_seen  = resync_seen;
        // live levels, not latched
        lock_status.flags.lock_latched = lock_latched;
        lock_status.flags.marker_found = marker_found;
    end

endmodule

/* hdl/diag_pager.sv */
// a tick that lands while the logger is busy is dropped, so a slow logger stretches the page cycle
`timescale 1ns/1ps

module diag_pager (
    input  logic                                cam1_pclk,
    input  logic                                diag_resetn,
    input  logic                                busy,
    input  logic [cam_diag_pkg::line_cnt_w-1:0] lines_per_field_last,
    input  logic [cam_diag_pkg::diag_w-1:0]     in_sof_cnt,
    input  logic [cam_diag_pkg::diag_w-1:0]     out_vsync_cnt,
    input  logic [cam_diag_pkg::diag_w-1:0]     sof_delta,
    input  cam_diag_pkg::diag_word_t            lock_status,
    output logic                                new_sample,
    output logic [cam_diag_pkg::page_w-1:0]     out_page,
    output logic [cam_diag_pkg::diag_w-1:0]     out_value
);
    import cam_diag_pkg::*;

    logic [$clog2(sample_interval)-1:0] tick_cnt;
    logic [page_w-1:0]                  page;
    logic [diag_w-1:0]                  sel_value;
    logic                               tick;
    logic                               take;

    assign tick = (tick_cnt == sample_interval - 1);
    assign take = tick & ~busy;

    always_comb begin
        case (page)
            page_lines:  sel_value = {{(diag_w - line_cnt_w){1'b0}}, lines_per_field_last};
            page_sof:    sel_value = in_sof_cnt;
            page_vsync:  sel_value = out_vsync_cnt;
            page_delta:  sel_value = sof_delta;
            page_status: sel_value = lock_status.raw;
            default:     sel_value = '0;
        endcase
    end

    always_ff @(posedge cam1_pclk or negedge diag_resetn) begin
        if (!diag_resetn) begin
            tick_cnt   <= '0;
            page       <= page_lines;
            new_sample <= 1'b0;
        end else begin
            tick_cnt   <= tick ? '0 : tick_cnt + 1'b1;
            new_sample <= take;
            if (take) begin
                page <= (page == page_count - 1) ? page_lines : page + 1'b1;
            end
        end
    end

    // sample held for the logger until the next accepted tick
    always_ff @(posedge cam1_pclk) begin
        if (take) begin
            out_page  <= page;
            out_value <= sel_value;
        end
    end

endmodule

/* hdl/i2c_frame_logger.sv */
// write-only, push-pull SCL/SDA; ACK is never sampled and no target may stretch the clock
`timescale 1ns/1ps

module i2c_frame_logger (
    input  logic                            cam1_pclk,
    input  logic                            diag_resetn,
    input  logic                            new_sample,
    input  logic [cam_diag_pkg::page_w-1:0] page,
    input  logic [cam_diag_pkg::diag_w-1:0] value,
    output logic                            dbg_i2c_scl,
    output logic                            dbg_i2c_sda,
    output logic                            busy
);
    import cam_diag_pkg::*;

    logic [$clog2(clks_per_half)-1:0] half_cnt;
    logic [6:0]                       step;
    logic [i2c_frame_bits-1:0]        shreg;
    logic                             half_end;
    logic                             mid_low;

    assign half_end = (half_cnt == clks_per_half - 1);

    // SDA moves in the middle of each SCL low half
    assign mid_low = step[0] && (step != i2c_last_step) &&
                     (half_cnt == clks_per_half / 2 - 1);

    // step 0 start, odd steps SCL low, even steps SCL high,
    // then stop low, stop high and bus free
    always_ff @(posedge cam1_pclk or negedge diag_resetn) begin
        if (!diag_resetn) begin
            busy        <= 1'b0;
            dbg_i2c_scl <= 1'b1;
            dbg_i2c_sda <= 1'b1;
            half_cnt    <= '0;
            step        <= '0;
        end else if (!busy) begin
            half_cnt <= '0;
            step     <= '0;
            if (new_sample) begin
                busy <= 1'b1;
                // START, SDA falls with SCL high
                dbg_i2c_sda <= 1'b0;
            end
        end else begin
            half_cnt <= half_end ? '0 : half_cnt + 1'b1;

            if (mid_low) begin
                dbg_i2c_sda <= shreg[i2c_frame_bits-1];
            end

            if (half_end) begin
                if (step == i2c_last_step) begin
                    busy <= 1'b0;
                end else begin
                    step <= step + 1'b1;
                    if (step == i2c_last_step - 1) begin
                        // STOP
                        dbg_i2c_sda <= 1'b1;
                    end else begin
                        dbg_i2c_scl <= step[0];
                    end
                end
            end
        end
    end

    // zeros shifted in drive SDA low for the stop low half
    always_ff @(posedge cam1_pclk) begin
        if (!busy && new_sample) begin
            shreg <= {i2c_addr, 1'b0, 1'b1,
                      page, 1'b1,
                      value[15:8], 1'b1,
                      value[7:0], 1'b1};
        end else if (mid_low) begin
            shreg <= {shreg[i2c_frame_bits-2:0], 1'b0};
        end
    end

endmodule

/* hdl/cam_diag_top.sv */
// field, line, marker, resync and lock inputs are taken as cam1_pclk-synchronous levels
`timescale 1ns/1ps

module cam_diag_top (
    input  logic cam1_pclk,
    input  logic cam_resetn,
    input  logic cam_line_valid,
    input  logic cam_field_toggle,
    input  logic hdmi_vsync_toggle,
    input  logic marker_found,
    input  logic resync_used,
    input  logic lock_latched,
    output logic dbg_i2c_scl,
    output logic dbg_i2c_sda
);
    import cam_diag_pkg::*;

    logic                  diag_resetn;
    logic [line_cnt_w-1:0] lines_per_field_last;
    logic [diag_w-1:0]     in_sof_cnt;
    logic [diag_w-1:0]     out_vsync_cnt;
    logic [diag_w-1:0]     sof_delta;
    diag_word_t            lock_status;
    logic                  new_sample;
    logic [page_w-1:0]     out_page;
    logic [diag_w-1:0]     out_value;
    logic                  busy;

    cam_reset_sync u_reset_sync (
        .cam1_pclk   (cam1_pclk),
        .cam_resetn  (cam_resetn),
        .diag_resetn (diag_resetn)
    );

    field_line_counter u_line_cnt (
        .cam1_pclk            (cam1_pclk),
        .diag_resetn          (diag_resetn),
        .cam_line_valid       (cam_line_valid),
        .cam_field_toggle     (cam_field_toggle),
        .lines_per_field_last (lines_per_field_last)
    );

    frame_sync_monitor u_sync_mon (
        .cam1_pclk         (cam1_pclk),
        .diag_resetn       (diag_resetn),
        .cam_field_toggle  (cam_field_toggle),
        .hdmi_vsync_toggle (hdmi_vsync_toggle),
        .marker_found      (marker_found),
        .resync_used       (resync_used),
        .lock_latched      (lock_latched),
        .in_sof_cnt        (in_sof_cnt),
        .out_vsync_cnt     (out_vsync_cnt),
        .sof_delta         (sof_delta),
        .lock_status       (lock_status)
    );

    diag_pager u_pager (
        .cam1_pclk            (cam1_pclk),
        .diag_resetn          (diag_resetn),
        .busy                 (busy),
        .lines_per_field_last (lines_per_field_last),
        .in_sof_cnt           (in_sof_cnt),
        .out_vsync_cnt        (out_vsync_cnt),
        .sof_delta            (sof_delta),
        .lock_status          (lock_status),
        .new_sample           (new_sample),
        .out_page             (out_page),
        .out_value            (out_value)
    );

    i2c_frame_logger u_logger (
        .cam1_pclk   (cam1_pclk),
        .diag_resetn (diag_resetn),
        .new_sample  (new_sample),
        .page        (out_page),
        .value       (out_value),
        .dbg_i2c_scl (dbg_i2c_scl),
        .dbg_i2c_sda (dbg_i2c_sda),
        .busy        (busy)
    );

endmodule

/* tb/i2c_frame_monitor.sv */
// write frames only; SDA must hold while SCL is high except at START and STOP, max 256 frames kept
`timescale 1ns/1ps

module i2c_frame_monitor (
    input logic scl,
    input logic sda
);
    localparam int max_frames = 256;

    logic [7:0]  addr_log  [max_frames];
    logic [7:0]  page_log  [max_frames];
    logic [15:0] value_log [max_frames];
    int          byte_log  [max_frames];
    int          nak_log   [max_frames];
    int          frame_cnt = 0;
    int          start_cnt = 0;
    logic        in_frame = 1'b0;
    logic        scl_q;
    logic        sda_q;
    int          bit_pos;
    int          byte_cnt;
    int          nak_cnt;
    logic [7:0]  cur;
    logic [7:0]  bytes [4];

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            // START
            start_cnt = start_cnt + 1;
            in_frame  = 1'b1;
            bit_pos   = 0;
            byte_cnt  = 0;
            nak_cnt   = 0;
            cur       = 8'h00;
            for (int i = 0; i < 4; i++) begin
                bytes[i] = 8'h00;
            end
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1
                     && in_frame) begin
            // STOP, any partial byte is dropped
            if (frame_cnt < max_frames) begin
                addr_log[frame_cnt]  = bytes[0];
                page_log[frame_cnt]  = bytes[1];
                value_log[frame_cnt] = {bytes[2], bytes[3]};
                byte_log[frame_cnt]  = byte_cnt;
                nak_log[frame_cnt]   = nak_cnt;
            end
            frame_cnt = frame_cnt + 1;
            in_frame  = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b0 && in_frame) begin
            if (bit_pos < 8) begin
                cur     = {cur[6:0], sda};
                bit_pos = bit_pos + 1;
            end else begin
                // ack slot is released high by the logger
                if (sda !== 1'b1) begin
                    nak_cnt = nak_cnt + 1;
                end
                if (byte_cnt < 4) begin
                    bytes[byte_cnt] = cur;
                end
                byte_cnt = byte_cnt + 1;
                bit_pos  = 0;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* tb/cam_diag_tb.sv */
// needs tb/cam_diag_vectors.txt relative to the run directory; a frame must fit in one sample interval
`timescale 1ns/1ps

module cam_diag_tb;
    import cam_diag_pkg::*;

    localparam int num_scen    = 6;
    localparam int vec_cols    = 11;
    localparam int hold_ivals  = 6;
    localparam int cycle_limit = num_scen * 7 * sample_interval + 4 * sample_interval;

    logic cam1_pclk;
    logic cam_resetn;
    logic cam_line_valid;
    logic cam_field_toggle;
    logic hdmi_vsync_toggle;
    logic marker_found;
    logic resync_used;
    logic lock_latched;
    logic dbg_i2c_scl;
    logic dbg_i2c_sda;

    logic [15:0]       vec_mem [num_scen * vec_cols];
    diag_word_t        exp_vals [page_count];
    integer            seed;
    int                cycle_cnt = 0;
    int                page_errs = 0;
    int                value_errs = 0;
    int                other_errs = 0;

    // reference model state
    logic [diag_w-1:0]     m_sof;
    logic [diag_w-1:0]     m_vsync;
    logic [line_cnt_w-1:0] m_line_run;
    logic [line_cnt_w-1:0] m_lines_last;
    logic                  m_ll;
    logic                  m_fm;
    logic                  m_rs;
    logic                  m_marker;
    logic                  m_resync;
    logic                  m_lock;

    cam_diag_top uut (
        .cam1_pclk         (cam1_pclk),
        .cam_resetn        (cam_resetn),
        .cam_line_valid    (cam_line_valid),
        .cam_field_toggle  (cam_field_toggle),
        .hdmi_vsync_toggle (hdmi_vsync_toggle),
        .marker_found      (marker_found),
        .resync_used       (resync_used),
        .lock_latched      (lock_latched),
        .dbg_i2c_scl       (dbg_i2c_scl),
        .dbg_i2c_sda       (dbg_i2c_sda)
    );

    i2c_frame_monitor mon (
        .scl (dbg_i2c_scl),
        .sda (dbg_i2c_sda)
    );

    always #20 cam1_pclk = ~cam1_pclk;

    always @(posedge cam1_pclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run stopped at the cycle limit before all scenarios finished");
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_page(input string name, input logic [page_w-1:0] got,
                              input logic [page_w-1:0] exp);
        if (got !== exp) begin
            page_errs++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_value(input string name, input diag_word_t got, input diag_word_t exp);
        if (got.raw !== exp.raw) begin
            value_errs++;
            $display("error: %s got %h expected %h", name, got.raw, exp.raw);
        end
    endtask

    task automatic next_cycle();
        @(posedge cam1_pclk);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_line();
        cam_line_valid = 1'b1;
        wait_cycles(2);
        cam_line_valid = 1'b0;
        wait_cycles(2);
        m_line_run = m_line_run + 1'b1;
    endtask

    task automatic start_field();
        cam_field_toggle = ~cam_field_toggle;
        m_lines_last = m_line_run;
        m_line_run   = '0;
        m_sof        = m_sof + 1'b1;
        m_fm         = m_fm | (m_sof != m_vsync);
        wait_cycles(8);
    endtask

    // the edge cycle compares the counts before the increment
    task automatic flip_vsync();
        hdmi_vsync_toggle = ~hdmi_vsync_toggle;
        m_ll    = !m_marker;
        m_rs    = m_resync;
        m_fm    = (m_sof != m_vsync);
        m_vsync = m_vsync + 1'b1;
        m_fm    = m_fm | (m_sof != m_vsync);
        wait_cycles(8);
    endtask

    task automatic set_levels(input logic marker, input logic resync);
        marker_found = marker;
        resync_used  = resync;
        m_marker     = marker;
        m_resync     = resync;
        m_ll         = m_ll | !marker;
        m_rs         = m_rs | resync;
        m_fm         = m_fm | (m_sof != m_vsync);
        wait_cycles(8);
    endtask

    task automatic set_lock(input logic lock);
        if (lock && !m_lock) begin
            m_ll = !m_marker;
            m_rs = m_resync;
            m_fm = (m_sof != m_vsync);
        end
        m_lock       = lock;
        lock_latched = lock;
        wait_cycles(8);
    endtask

    task automatic check_frames(input int first, input int last);
        logic [page_w-1:0] exp_page;
        if (last - first < page_count) begin
            other_errs++;
            $display("only %0d frames were decoded during the hold", last - first);
            return;
        end
        for (int i = last - page_count; i < last; i++) begin
            if (mon.byte_log[i] != 4 || mon.nak_log[i] != 0) begin
                other_errs++;
                $display("frame %0d had %0d bytes and %0d low ack slots",
                         i, mon.byte_log[i], mon.nak_log[i]);
            end
            check_page("addr byte", mon.addr_log[i], 8'hba);
            // one page step per frame, starting from page 0 after reset
            exp_page = page_w'(i % page_count);
            check_page("page", mon.page_log[i], exp_page);
            check_value("frame value", mon.value_log[i], exp_vals[i % page_count]);
        end
    endtask

    initial begin
        int base;
        int first;
        diag_word_t st;
        cam1_pclk = 1'b0;
        cam_resetn = 1'b0;
        cam_line_valid = 1'b0;
        cam_field_toggle = 1'b0;
        hdmi_vsync_toggle = 1'b0;
        marker_found = 1'b1;
        resync_used = 1'b0;
        lock_latched = 1'b0;
        seed = 32'hf010;
        m_sof = '0;
        m_vsync = '0;
        m_line_run = '0;
        m_lines_last = '0;
        {m_ll, m_fm, m_rs} = 3'b000;
        m_marker = 1'b1;
        m_resync = 1'b0;
        m_lock = 1'b0;
        $readmemh("tb/cam_diag_vectors.txt", vec_mem);
        repeat (10) @(posedge cam1_pclk);
        #2;
        cam_resetn = 1'b1;

        // bus stays idle until the first tick
        for (int i = 0; i < sample_interval - 64; i++) begin
            next_cycle();
            if (dbg_i2c_scl !== 1'b1 || dbg_i2c_sda !== 1'b1) begin
                other_errs++;
                $display("bus left idle at cycle %0d before the first sample", i);
            end
        end
        if (mon.start_cnt != 0) begin
            other_errs++;
            $display("a START appeared before the first sample tick");
        end

        for (int s = 0; s < num_scen; s++) begin
            base = s * vec_cols;
            set_levels(vec_mem[base+3][0], vec_mem[base+4][0]);
            for (int f = 0; f < int'(vec_mem[base]); f++) begin
                for (int l = 0; l < int'(vec_mem[base+1]); l++) begin
                    send_line();
                end
                start_field();
                for (int v = 0; v < int'(vec_mem[base+2]); v++) begin
                    flip_vsync();
                end
                wait_cycles(8 + ($random(seed) & 31));
            end
            resync_used = 1'b0;
            m_resync = 1'b0;
            wait_cycles(8);
            set_lock(vec_mem[base+5][0]);

            st.raw = '0;
            st.flags.lock_lost = m_ll;
            st.flags.frame_miss = m_fm;
            st.flags.resync_seen = m_rs;
            st.flags.lock_latched = m_lock;
            st.flags.marker_found = m_marker;
            exp_vals[0].raw = {{(diag_w - line_cnt_w){1'b0}}, m_lines_last};
            exp_vals[1].raw = m_sof;
            exp_vals[2].raw = m_vsync;
            exp_vals[3].raw = m_sof - m_vsync;
            exp_vals[4] = st;
            for (int p = 0; p < page_count; p++) begin
                check_value("vector file value", vec_mem[base+6+p], exp_vals[p]);
            end

            first = mon.frame_cnt;
            wait_cycles(hold_ivals * sample_interval);
            check_frames(first, mon.frame_cnt);
        end

        $display("errors: page %0d value %0d other %0d", page_errs, value_errs, other_errs);
        if (page_errs + value_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* cam_diag.f */
hdl/cam_diag_pkg.sv
hdl/cam_reset_sync.sv
hdl/field_line_counter.sv
hdl/frame_sync_monitor.sv
hdl/diag_pager.sv
hdl/i2c_frame_logger.sv
hdl/cam_diag_top.sv
tb/i2c_frame_monitor.sv
tb/cam_diag_tb.sv

/* Makefile */
TOP = cam_diag_tb

.PHONY: simulate clean

# passes only if the run prints the pass message
simulate:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f cam_diag.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf obj_dir

/* tb/cam_diag_vectors.txt */
// fields lines vsyncs marker resync lock | page0 lines, page1 sof, page2 vsync, page3 delta,
// page4 status; hex words, one scenario per line, scenarios run in order
3 5 1 1 0 0  0005 0003 0003 0000 0009
2 7 2 0 1 0  0007 0005 0007 fffe 001c
2 4 0 1 0 1  0004 0007 0007 0000 0003
1 9 3 1 0 1  0009 0008 000a fffe 000b
4 2 1 1 1 0  0002 000c 000e fffe 000d
3 6 0 0 0 1  0006 000f 000e 0001 001a
